/* hdl/seed_pkg.sv */
`default_nettype none

package seed_pkg;

  // Field widths of the internal word
  localparam int OPERAND_W = 68;
  localparam int EXP_W = 12;
  localparam int BUCKET_W = 6;
  localparam int ADDR_W = 9;
  localparam int MASK_W = 6;

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [EXP_W-1:0] exponent_t;
  typedef logic [BUCKET_W-1:0] bucket_t;
  typedef logic [ADDR_W-1:0] table_addr_t;

  typedef enum logic [2:0] {
    OP_RECIP    = 3'd0,
    OP_RSQRT    = 3'd1,
    OP_RECIP_HI = 3'd2,
    OP_RSQRT_HI = 3'd3,
    OP_FAR      = 3'd4,
    OP_TRUNC_S1 = 3'd5,
    OP_TRUNC_S2 = 3'd6,
    OP_TRUNC_HI = 3'd7
  } seed_op_t;

  // Table geometry, four slots per bucket below the far region
  localparam int TABLE_DEPTH = 320;
  localparam table_addr_t TABLE_LAST = table_addr_t'(TABLE_DEPTH - 1);
  localparam table_addr_t FAR_BASE = 9'd256;

  localparam exponent_t EXP_BASE_LO = 12'd2040;
  localparam exponent_t EXP_BASE_HI = 12'd2044;
  localparam exponent_t WINDOW_SPAN = 12'd6; // Exponents past the base that get a bucket

  localparam int SIGN_BIT = 64;
  localparam int MASK_LSB = 47; // Truncate window is bits 52:47

endpackage

`default_nettype wire

/* hdl/seed_index.sv */
`default_nettype none

module seed_index (
  input  seed_pkg::seed_op_t    op,
  input  seed_pkg::operand_t    operand,
  output seed_pkg::table_addr_t addr,
  output logic                  flip_sign,
  output logic                  trunc_op,
  output seed_pkg::operand_t    trunc_result
);

  seed_pkg::exponent_t exponent;
  seed_pkg::exponent_t j_lo;
  seed_pkg::exponent_t j_hi;
  logic lo_window;
  logic hi_window;
  seed_pkg::bucket_t bucket_lo;
  seed_pkg::bucket_t bucket_root;
  seed_pkg::bucket_t bucket_hi;
  seed_pkg::bucket_t bucket;
  logic [1:0] slot;
  logic [2:0] mask_width;
  logic [seed_pkg::MASK_W-1:0] mask_low;
  logic [seed_pkg::MASK_W-1:0] mask;
  seed_pkg::operand_t mask_word;

  // Leading one, then the top j-1 mantissa bits right-aligned
  function automatic seed_pkg::bucket_t lead_bucket(
    input logic       in_window,
    input logic [2:0] j,
    input logic [4:0] mant_top
  );
    logic [4:0] tail;
    tail = mant_top >> (3'd6 - j);
    if (in_window) begin
      lead_bucket = {1'b1, tail};
    end else begin
      lead_bucket = '0;
    end
  endfunction

  // Parity on top, then the low rule shifted down by one exponent
  function automatic seed_pkg::bucket_t root_bucket(
    input logic       in_window,
    input logic       parity,
    input logic [2:0] j,
    input logic [3:0] mant_top
  );
    logic [3:0] tail;
    tail = mant_top >> (3'd6 - j);
    if (!in_window) begin
      root_bucket = '0;
    end else if (j == 3'd1) begin
      root_bucket = {parity, 5'b0};
    end else begin
      root_bucket = {parity, 1'b1, tail};
    end
  endfunction

  assign exponent = operand[65:54];
  assign j_lo = exponent - seed_pkg::EXP_BASE_LO; // Wraps high below the base
  assign j_hi = exponent - seed_pkg::EXP_BASE_HI;
  assign lo_window = (j_lo >= 12'd1) && (j_lo <= seed_pkg::WINDOW_SPAN);
  assign hi_window = (j_hi >= 12'd1) && (j_hi <= seed_pkg::WINDOW_SPAN);

  assign bucket_lo = lead_bucket(lo_window, j_lo[2:0], operand[53:49]);
  assign bucket_hi = lead_bucket(hi_window, j_hi[2:0], operand[53:49]);
  assign bucket_root = root_bucket(lo_window, operand[54], j_lo[2:0], operand[53:50]);

  always_comb begin
    bucket = '0;
    slot = 2'd0;
    case (op)
      seed_pkg::OP_RECIP: begin
        bucket = bucket_lo;
        slot = 2'd0;
      end
      seed_pkg::OP_RSQRT: begin
        bucket = bucket_root;
        slot = 2'd1;
      end
      seed_pkg::OP_RECIP_HI: begin
        bucket = bucket_hi;
        slot = 2'd2;
      end
      seed_pkg::OP_RSQRT_HI: begin
        bucket = bucket_hi;
        slot = 2'd3;
      end
      seed_pkg::OP_FAR: bucket = bucket_hi;
      default: bucket = '0; // Truncates skip the table
    endcase
  end

  always_comb begin
    if (op == seed_pkg::OP_FAR) begin
      addr = seed_pkg::FAR_BASE + {3'b0, bucket}; // One entry per bucket
    end else begin
      addr = {1'b0, bucket, slot};
    end
  end

  assign flip_sign = ((op == seed_pkg::OP_RECIP) || (op == seed_pkg::OP_RECIP_HI)) &&
                     operand[seed_pkg::SIGN_BIT];

  assign trunc_op = (op == seed_pkg::OP_TRUNC_S1) || (op == seed_pkg::OP_TRUNC_S2) ||
                    (op == seed_pkg::OP_TRUNC_HI);

  always_comb begin
    if (op == seed_pkg::OP_TRUNC_HI) begin
      mask_width = hi_window ? j_hi[2:0] : 3'd0;
    end else begin
      mask_width = lo_window ? j_lo[2:0] : 3'd0;
    end
  end

  assign mask_low = ~(6'h3f << mask_width); // m low bits set

  always_comb begin
    if (op == seed_pkg::OP_TRUNC_S2) begin
      mask = mask_low << 2;
    end else begin
      mask = mask_low << 1;
    end
    mask_word = '0;
    mask_word[seed_pkg::MASK_LSB +: seed_pkg::MASK_W] = mask;
  end

  assign trunc_result = operand & mask_word;

endmodule

`default_nettype wire

/* hdl/seed_table.sv */
`default_nettype none

module seed_table (
  input  logic                  clk,
  input  logic                  wr_en,
  input  seed_pkg::table_addr_t wr_addr,
  input  seed_pkg::operand_t    wr_data,
  input  logic                  rd_en,
  input  seed_pkg::table_addr_t rd_addr,
  output seed_pkg::operand_t    rd_data
);

  seed_pkg::operand_t mem [seed_pkg::TABLE_DEPTH];

  // Addresses past the last entry are dropped
  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr <= seed_pkg::TABLE_LAST)) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Old entry wins on a same-address read and write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* hdl/seed_pipe.sv */
`default_nettype none

module seed_pipe (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  output logic               in_ready,
  input  logic               flip_sign,
  input  logic               trunc_op,
  input  seed_pkg::operand_t trunc_result,
  output logic               table_rd_en,
  input  seed_pkg::operand_t table_data,
  output logic               out_valid,
  input  logic               out_ready,
  output seed_pkg::operand_t out_result
);

  logic s1_valid;
  logic s2_valid;
  logic s1_move;
  logic accept;

  // Stage 1 metadata, sits beside the table read register
  logic s1_flip;
  logic s1_trunc;
  seed_pkg::operand_t s1_trunc_result;

  seed_pkg::operand_t flip_mask;
  seed_pkg::operand_t s1_result;

  assign s1_move = !s2_valid || out_ready;
  assign in_ready = !s1_valid || s1_move;
  assign accept = in_valid && in_ready;
  assign table_rd_en = accept && !trunc_op; // Table data holds through a stall

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (accept) begin
      s1_valid <= 1'b1;
    end else if (s1_move) begin
      s1_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_flip <= flip_sign;
      s1_trunc <= trunc_op;
      s1_trunc_result <= trunc_result;
    end
  end

  always_comb begin
    flip_mask = '0;
    flip_mask[seed_pkg::SIGN_BIT] = s1_flip;
    if (s1_trunc) begin
      s1_result = s1_trunc_result;
    end else begin
      s1_result = table_data ^ flip_mask;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else if (s1_move) begin
      s2_valid <= s1_valid;
    end
  end

  // Output register only loads on a real stage 1 entry
  always_ff @(posedge clk) begin
    if (s1_move && s1_valid) begin
      out_result <= s1_result;
    end
  end

  assign out_valid = s2_valid;

endmodule

`default_nettype wire

/* hdl/seed_unit_top.sv */
`default_nettype none

module seed_unit_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  seed_pkg::seed_op_t    in_op,
  input  seed_pkg::operand_t    in_operand,
  output logic                  out_valid,
  input  logic                  out_ready,
  output seed_pkg::operand_t    out_result,
  input  logic                  load_valid,
  input  seed_pkg::table_addr_t load_addr,
  input  seed_pkg::operand_t    load_data
);

  seed_pkg::table_addr_t rd_addr;
  seed_pkg::operand_t    table_data;
  seed_pkg::operand_t    trunc_result;
  logic                  flip_sign;
  logic                  trunc_op;
  logic                  table_rd_en;

  seed_index i_index (
    .op           (in_op),
    .operand      (in_operand),
    .addr         (rd_addr),
    .flip_sign    (flip_sign),
    .trunc_op     (trunc_op),
    .trunc_result (trunc_result)
  );

  // Load port writes straight into the table
  seed_table i_table (
    .clk     (clk),
    .wr_en   (load_valid),
    .wr_addr (load_addr),
    .wr_data (load_data),
    .rd_en   (table_rd_en),
    .rd_addr (rd_addr),
    .rd_data (table_data)
  );

  seed_pipe i_pipe (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .flip_sign    (flip_sign),
    .trunc_op     (trunc_op),
    .trunc_result (trunc_result),
    .table_rd_en  (table_rd_en),
    .table_data   (table_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_result   (out_result)
  );

endmodule

`default_nettype wire

/* sim/seed_model.svh */
`ifndef SEED_MODEL_SVH
`define SEED_MODEL_SVH

// Top n mantissa bits, bit 53 downward, as a number
function automatic int top_bits(seed_pkg::operand_t word, int n);
  int value;
  value = 0;
  for (int k = 0; k < n; k++) begin
    value = value * 2 + int'(word[53 - k]);
  end
  return value;
endfunction

function automatic int model_lead_bucket(seed_pkg::operand_t word, int base);
  int j;
  j = int'(word[65:54]) - base;
  if (j >= 1 && j <= 6) begin
    return 32 + top_bits(word, j - 1);
  end
  return 0;
endfunction

function automatic int model_root_bucket(seed_pkg::operand_t word);
  int j;
  int bucket;
  j = int'(word[65:54]) - int'(seed_pkg::EXP_BASE_LO);
  bucket = 0;
  if (j >= 1 && j <= 6) begin
    bucket = 32 * int'(word[54]); // Exponent parity
    if (j > 1) begin
      bucket = bucket + 16 + top_bits(word, j - 2);
    end
  end
  return bucket;
endfunction

function automatic int model_addr(seed_pkg::seed_op_t op, seed_pkg::operand_t word);
  int lo;
  int hi;
  lo = int'(seed_pkg::EXP_BASE_LO);
  hi = int'(seed_pkg::EXP_BASE_HI);
  case (op)
    seed_pkg::OP_RECIP:    return model_lead_bucket(word, lo) * 4;
    seed_pkg::OP_RSQRT:    return model_root_bucket(word) * 4 + 1;
    seed_pkg::OP_RECIP_HI: return model_lead_bucket(word, hi) * 4 + 2;
    seed_pkg::OP_RSQRT_HI: return model_lead_bucket(word, hi) * 4 + 3;
    seed_pkg::OP_FAR:      return int'(seed_pkg::FAR_BASE) + model_lead_bucket(word, hi);
    default:               return 0;
  endcase
endfunction

function automatic bit model_is_trunc(seed_pkg::seed_op_t op);
  return op == seed_pkg::OP_TRUNC_S1 || op == seed_pkg::OP_TRUNC_S2 ||
         op == seed_pkg::OP_TRUNC_HI;
endfunction

function automatic seed_pkg::operand_t model_trunc(seed_pkg::seed_op_t op,
                                                   seed_pkg::operand_t word);
  int j;
  int m;
  int mask;
  seed_pkg::operand_t result;
  if (op == seed_pkg::OP_TRUNC_HI) begin
    j = int'(word[65:54]) - 2044;
  end else begin
    j = int'(word[65:54]) - 2040;
  end
  m = (j >= 1 && j <= 6) ? j : 0;
  mask = ((1 << m) - 1) << ((op == seed_pkg::OP_TRUNC_S2) ? 2 : 1);
  mask = mask & 63;
  result = '0;
  for (int k = 0; k < 6; k++) begin
    if (((mask >> k) & 1) == 1) begin
      result[47 + k] = word[47 + k]; // Window is bits 52:47
    end
  end
  return result;
endfunction

function automatic seed_pkg::operand_t model_result(seed_pkg::seed_op_t op,
                                                    seed_pkg::operand_t word,
                                                    seed_pkg::operand_t entry);
  seed_pkg::operand_t result;
  if (model_is_trunc(op)) begin
    return model_trunc(op, word);
  end
  result = entry;
  if ((op == seed_pkg::OP_RECIP || op == seed_pkg::OP_RECIP_HI) && word[64]) begin
    result[64] = ~result[64];
  end
  return result;
endfunction

`endif

/* sim/seed_tb.sv */
`default_nettype none

module seed_tb;

  localparam int unsigned SEED = 32'ha498;
  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_CYCLES = 20000; // About ten times the full test length

  logic clk = 1'b0;
  logic reset;
  logic in_valid;
  logic in_ready;
  seed_pkg::seed_op_t in_op;
  seed_pkg::operand_t in_operand;
  logic out_valid;
  logic out_ready;
  seed_pkg::operand_t out_result;
  logic load_valid;
  seed_pkg::table_addr_t load_addr;
  seed_pkg::operand_t load_data;

  seed_pkg::operand_t model_table [seed_pkg::TABLE_DEPTH];
  seed_pkg::operand_t expect_q [$];
  int accept_cycle_q [$];
  bit trunc_q [$];

  string test_name = "setup";
  int cycle_count = 0;
  bit check_latency = 1'b0;
  bit random_ready = 1'b0;
  bit hold_valid = 1'b0;
  seed_pkg::operand_t hold_value;
  int unsigned seed_value;

  `include "seed_model.svh"

  seed_unit_top i_dut (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_op      (in_op),
    .in_operand (in_operand),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  always #HALF_PERIOD clk = ~clk;

  task automatic report_value(string what, seed_pkg::operand_t expected,
                              seed_pkg::operand_t actual);
    $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(string what);
    $display("Error in %s: %s", test_name, what);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  // Scoreboard, sampled at the edge where transfers happen
  always @(posedge clk) begin : monitor
    seed_pkg::operand_t expected;
    int accepted_at;
    bit was_trunc;
    int addr;
    if (!reset) begin
      if (hold_valid && out_valid) begin
        assert (out_result == hold_value)
          else report_value("stalled out_result", hold_value, out_result);
      end
      if (expect_q.size() == 2 && !out_ready) begin
        assert (!in_ready) else report_error("in_ready high while two results wait");
      end
      if (expect_q.size() == 0) begin
        assert (in_ready) else report_error("in_ready low with an empty pipe");
      end
      if (out_valid && out_ready) begin
        assert (expect_q.size() != 0) else report_error("result with no request pending");
        expected = expect_q.pop_front();
        accepted_at = accept_cycle_q.pop_front();
        was_trunc = trunc_q.pop_front();
        if (was_trunc) begin
          for (int k = 0; k < seed_pkg::TABLE_DEPTH; k++) begin
            assert (out_result != model_table[k])
              else report_error("table entry showed up in a truncate result");
          end
        end
        assert (out_result == expected) else report_value("out_result", expected, out_result);
        if (check_latency) begin
          assert (cycle_count - accepted_at == 2)
            else report_value("latency", seed_pkg::operand_t'(2),
                              seed_pkg::operand_t'(cycle_count - accepted_at));
        end
      end
      if (in_valid && in_ready) begin
        addr = model_addr(in_op, in_operand);
        expect_q.push_back(model_result(in_op, in_operand, model_table[addr]));
        accept_cycle_q.push_back(cycle_count);
        trunc_q.push_back(model_is_trunc(in_op));
      end
      // After the lookup, so a same-cycle write returns the old entry
      if (load_valid && int'(load_addr) < seed_pkg::TABLE_DEPTH) begin
        model_table[load_addr] = load_data;
      end
      hold_valid = out_valid && !out_ready;
      hold_value = out_result;
    end
  end

  function automatic seed_pkg::operand_t random_word();
    logic [95:0] wide;
    wide = {$urandom(), $urandom(), $urandom()};
    return wide[67:0];
  endfunction

  // Bit 64 is part of the exponent, so the sign follows from it
  function automatic seed_pkg::operand_t make_operand(int exponent);
    seed_pkg::operand_t word;
    word = random_word();
    word[65:54] = seed_pkg::exponent_t'(exponent);
    return word;
  endfunction

  task automatic step_out_ready();
    if (random_ready) begin
      out_ready = ($urandom_range(0, 1) == 1);
    end
  endtask

  task automatic send_request(seed_pkg::seed_op_t op, seed_pkg::operand_t operand);
    bit took;
    in_valid = 1'b1;
    in_op = op;
    in_operand = operand;
    do begin
      @(posedge clk);
      took = in_ready;
      @(negedge clk);
      step_out_ready();
    end while (!took);
  endtask

  task automatic wait_drain();
    in_valid = 1'b0;
    while (expect_q.size() != 0) begin
      @(negedge clk);
      step_out_ready();
    end
  endtask

  task automatic load_entry(seed_pkg::table_addr_t addr, seed_pkg::operand_t data);
    load_valid = 1'b1;
    load_addr = addr;
    load_data = data;
    @(negedge clk);
    step_out_ready();
    load_valid = 1'b0;
  endtask

  task automatic test_reset_state();
    test_name = "reset state";
    assert (out_valid == 1'b0)
      else report_value("out_valid", '0, seed_pkg::operand_t'(out_valid));
    assert (in_ready == 1'b1)
      else report_value("in_ready", seed_pkg::operand_t'(1), seed_pkg::operand_t'(in_ready));
    @(negedge clk);
  endtask

  task automatic test_base_lookups();
    test_name = "base lookups";
    for (int a = 0; a < seed_pkg::TABLE_DEPTH; a++) begin
      load_entry(seed_pkg::table_addr_t'(a), random_word());
    end
    check_latency = 1'b1;
    for (int e = 2038; e <= 2048; e++) begin
      for (int n = 0; n < 6; n++) begin
        send_request(seed_pkg::OP_RECIP, make_operand(e));
        send_request(seed_pkg::OP_RSQRT, make_operand(e));
      end
    end
    wait_drain();
  endtask

  task automatic test_high_far();
    test_name = "high and far lookups";
    for (int e = 2043; e <= 2052; e++) begin
      for (int n = 0; n < 4; n++) begin
        send_request(seed_pkg::OP_RECIP_HI, make_operand(e));
        send_request(seed_pkg::OP_RSQRT_HI, make_operand(e));
        send_request(seed_pkg::OP_FAR, make_operand(e));
      end
    end
    wait_drain();
  endtask

  task automatic test_truncate();
    test_name = "truncate";
    for (int e = 2039; e <= 2051; e++) begin
      for (int n = 0; n < 3; n++) begin
        send_request(seed_pkg::OP_TRUNC_S1, make_operand(e));
        send_request(seed_pkg::OP_TRUNC_S2, make_operand(e));
        send_request(seed_pkg::OP_TRUNC_HI, make_operand(e));
      end
    end
    wait_drain();
    check_latency = 1'b0;
  endtask

  task automatic test_back_pressure();
    logic [2:0] code;
    test_name = "back-pressure";
    random_ready = 1'b1;
    for (int n = 0; n < 200; n++) begin
      code = 3'($urandom_range(0, 7));
      send_request(seed_pkg::seed_op_t'(code), make_operand(2036 + $urandom_range(0, 18)));
      if ($urandom_range(0, 3) == 0) begin
        in_valid = 1'b0; // Idle gap
        @(negedge clk);
        step_out_ready();
      end
    end
    wait_drain();
    random_ready = 1'b0;
    out_ready = 1'b1;
  endtask

  task automatic test_table_rewrite();
    logic [2:0] code;
    seed_pkg::seed_op_t op;
    seed_pkg::operand_t operand;
    int addr;
    test_name = "table rewrite";
    for (int k = 0; k < 8; k++) begin
      code = 3'($urandom_range(0, 4));
      op = seed_pkg::seed_op_t'(code);
      operand = make_operand((op <= seed_pkg::OP_RSQRT) ? 2041 + k % 6 : 2045 + k % 6);
      addr = model_addr(op, operand);
      send_request(op, operand);
      wait_drain();
      load_entry(seed_pkg::table_addr_t'(addr), random_word());
      load_entry(seed_pkg::table_addr_t'(320 + k), random_word()); // Out of range, dropped
      send_request(op, operand);
      wait_drain();
    end
  endtask

  initial begin
    seed_value = $urandom(SEED);
    reset = 1'b1;
    in_valid = 1'b0;
    in_op = seed_pkg::OP_RECIP;
    in_operand = '0;
    out_ready = 1'b1;
    load_valid = 1'b0;
    load_addr = '0;
    load_data = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_base_lookups();
    test_high_far();
    test_truncate();
    test_back_pressure();
    test_table_rewrite();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+sim
hdl/seed_pkg.sv
hdl/seed_index.sv
hdl/seed_table.sv
hdl/seed_pipe.sv
hdl/seed_unit_top.sv
sim/seed_tb.sv

/* Makefile */
# Verilator build and run of the seed-estimate unit testbench

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module seed_tb -f files.f -Mdir obj_dir -o seed_sim
	obj_dir/seed_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
